/* hw/mipsExecPkg.sv */
// Shared encodings and types for the MIPS execute stage.
// Modules import this package in their bodies and use scoped names in port lists.

package mipsExecPkg;

    // ALU operations. LUI runs as SLL by 16 on the zero-extended immediate
    typedef enum logic [4:0] {
        aluAdd,  aluAddu, aluSub,  aluSubu,
        aluSll,  aluSllv, aluSra,  aluSrav, aluSrl, aluSrlv,
        aluAnd,  aluOr,   aluNor,  aluXor,
        aluSlt,  aluSltu, aluMovn, aluMovz, aluClz, aluClo
    } aluOpT;

    // ------------------------------------------------------------------------
    // Opcodes
    localparam logic [5:0] opSpecial  = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opAddiu    = 6'h09;
    localparam logic [5:0] opSlti     = 6'h0a;
    localparam logic [5:0] opSltiu    = 6'h0b;
    localparam logic [5:0] opAndi     = 6'h0c;
    localparam logic [5:0] opOri      = 6'h0d;
    localparam logic [5:0] opXori     = 6'h0e;
    localparam logic [5:0] opLui      = 6'h0f;

    // ------------------------------------------------------------------------
    // Function field, SPECIAL unless noted
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnMovz = 6'h0a;
    localparam logic [5:0] fnMovn = 6'h0b;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;
    localparam logic [5:0] fnClz  = 6'h20; // SPECIAL2
    localparam logic [5:0] fnClo  = 6'h21; // SPECIAL2

    // ------------------------------------------------------------------------
    // Decoder output
    typedef struct packed {
        aluOpT op;
        logic  useImm;
        logic  signImm;
        logic  luiShift;
        logic  varShift;
        logic  destIsRt;
        logic  regWrite;
        logic  trapOnOvf;
        logic  illegal;
    } aluCtrlT;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
    } execReqT;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [4:0]  destReg;
        logic        writeEn;
        logic        ovfTrap;
        logic        illegal;
    } execResT;

endpackage

/* hw/aluDecoder.sv */
// Instruction decoder for the execute stage.
// Maps opcode and function field to an ALU operation and operand controls.
// Purely combinational.

`timescale 1ns/10ps

module aluDecoder (
    input  logic [31:0]          instr,
    output mipsExecPkg::aluCtrlT ctrl
);
    import mipsExecPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb
    begin
        ctrl = '0;

        // Operation select
        case (opcode)
            opSpecial:
                case (funct)
                    fnAdd  : ctrl.op = aluAdd;
                    fnAddu : ctrl.op = aluAddu;
                    fnSub  : ctrl.op = aluSub;
                    fnSubu : ctrl.op = aluSubu;
                    fnSll  : ctrl.op = aluSll;
                    fnSllv : ctrl.op = aluSllv;
                    fnSra  : ctrl.op = aluSra;
                    fnSrav : ctrl.op = aluSrav;
                    fnSrl  : ctrl.op = aluSrl;
                    fnSrlv : ctrl.op = aluSrlv;
                    fnAnd  : ctrl.op = aluAnd;
                    fnOr   : ctrl.op = aluOr;
                    fnNor  : ctrl.op = aluNor;
                    fnXor  : ctrl.op = aluXor;
                    fnSlt  : ctrl.op = aluSlt;
                    fnSltu : ctrl.op = aluSltu;
                    fnMovn : ctrl.op = aluMovn;
                    fnMovz : ctrl.op = aluMovz;
                    default: ctrl.illegal = 1'b1;
                endcase

            opSpecial2:
                case (funct)
                    fnClz  : ctrl.op = aluClz;
                    fnClo  : ctrl.op = aluClo;
                    default: ctrl.illegal = 1'b1;
                endcase

            opAddi : ctrl.op = aluAdd;
            opAddiu: ctrl.op = aluAddu;
            opSlti : ctrl.op = aluSlt;
            opSltiu: ctrl.op = aluSltu;
            opAndi : ctrl.op = aluAnd;
            opOri  : ctrl.op = aluOr;
            opXori : ctrl.op = aluXor;
            opLui  : ctrl.op = aluSll;   // Imm shifted left by 16
            default: ctrl.illegal = 1'b1;
        endcase

        // Operand controls
        ctrl.regWrite  = !ctrl.illegal;
        ctrl.trapOnOvf = !ctrl.illegal && (ctrl.op inside {aluAdd, aluSub}); // ADD, SUB, ADDI
        ctrl.varShift  = ctrl.op inside {aluSllv, aluSrlv, aluSrav};
        ctrl.useImm    = !(opcode inside {opSpecial, opSpecial2});
        ctrl.destIsRt  = ctrl.useImm;
        ctrl.signImm   = opcode inside {opAddi, opAddiu, opSlti, opSltiu};
        ctrl.luiShift  = (opcode == opLui);
    end

endmodule

/* hw/alu.sv */
// 32-bit integer ALU.
// Combinational; operand B and the shift amount are selected by the caller.
// en drops for a MOVN or MOVZ whose condition fails, ovf flags signed overflow.

`timescale 1ns/10ps

module alu (
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    input  logic [4:0]         shamt,
    input  mipsExecPkg::aluOpT op,
    output logic [31:0]        out,
    output logic               en,
    output logic               ovf
);
    import mipsExecPkg::*;

    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] leadIn;
    logic [5:0]  leadCnt;

    assign sum  = a + b;
    assign diff = a - b;

    // ------------------------------------------------------------------------
    // Leading zero / one count

    // CLO counts zeros of the inverted operand
    assign leadIn = (op == aluClo) ? ~a : a;

    always_comb
    begin
        leadCnt = 6'd32;                 // All zero
        for (int i = 0; i < 32; i++)
        begin
            if (leadIn[i])
                leadCnt = 6'(31 - i);    // Highest set bit wins
        end
    end

    // ------------------------------------------------------------------------
    // Operation select

    always_comb
    begin
        out = '0;
        en  = 1'b1;
        ovf = 1'b0;

        case (op)
            aluAdd:
            begin
                out = sum;
                ovf = (a[31] == b[31]) && (sum[31] != a[31]);
            end

            aluAddu: out = sum;

            aluSub:
            begin
                out = diff;
                ovf = (a[31] != b[31]) && (diff[31] != a[31]);
            end

            aluSubu: out = diff;

            // Variable forms already carry rs[4:0] in shamt
            aluSll, aluSllv: out = b << shamt;
            aluSrl, aluSrlv: out = b >> shamt;
            aluSra, aluSrav: out = $signed(b) >>> shamt;

            aluAnd : out = a & b;
            aluOr  : out = a | b;
            aluNor : out = ~(a | b);
            aluXor : out = a ^ b;

            aluSlt : out = {31'b0, $signed(a) < $signed(b)};
            aluSltu: out = {31'b0, a < b};

            aluMovn:
            begin
                out = a;
                en  = (b != '0);
            end

            aluMovz:
            begin
                out = a;
                en  = (b == '0);
            end

            aluClz, aluClo: out = {26'b0, leadCnt};

            default: out = '0;
        endcase
    end

endmodule

/* hw/execStage.sv */
// Execute stage: operand select, ALU and the result register.
// One request per cycle in, one registered result out a cycle later.
// Write enable folds in the move condition, overflow trap and illegal decode.

`timescale 1ns/10ps

module execStage (
    input  logic                 clk,
    input  logic                 rst,
    input  mipsExecPkg::execReqT req,
    input  mipsExecPkg::aluCtrlT ctrl,
    output mipsExecPkg::execResT res
);

    logic [15:0] imm;
    logic [31:0] immExt;
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic [4:0]  destReg;
    logic [31:0] aluOut;
    logic        aluEn;
    logic        aluOvf;
    logic        ovfTrap;
    logic        writeEn;

    // ------------------------------------------------------------------------
    // Operands

    assign imm    = req.instr[15:0];
    assign immExt = ctrl.signImm ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign opB    = ctrl.useImm ? immExt : req.rtVal;

    always_comb
    begin
        if (ctrl.luiShift)
            shamt = 5'd16;
        else if (ctrl.varShift)
            shamt = req.rsVal[4:0];      // Low five bits only
        else
            shamt = req.instr[10:6];
    end

    assign destReg = ctrl.destIsRt ? req.instr[20:16] : req.instr[15:11];

    alu u_alu (
        .a     (req.rsVal),
        .b     (opB),
        .shamt (shamt),
        .op    (ctrl.op),
        .out   (aluOut),
        .en    (aluEn),
        .ovf   (aluOvf)
    );

    // ------------------------------------------------------------------------
    // Write enable and trap

    assign ovfTrap = ctrl.trapOnOvf & aluOvf;
    assign writeEn = ctrl.regWrite & aluEn & ~ovfTrap & ~ctrl.illegal;

    // ------------------------------------------------------------------------
    // Result register

    always_ff @(posedge clk)
    begin
        res.result  <= aluOut;
        res.destReg <= destReg;

        if (rst)
        begin
            res.valid   <= 1'b0;
            res.writeEn <= 1'b0;
            res.ovfTrap <= 1'b0;
            res.illegal <= 1'b0;
        end
        else
        begin
            res.valid   <= req.valid;
            res.writeEn <= req.valid & writeEn;
            res.ovfTrap <= req.valid & ovfTrap;
            res.illegal <= req.valid & ctrl.illegal;
        end
    end

endmodule

/* hw/mipsExecTop.sv */
// Top level of the execute subsystem.
// Decodes the incoming instruction and hands it to the execute stage.
// Fixed latency of one cycle from req to res.

`timescale 1ns/10ps

module mipsExecTop (
    input  logic                 clk,
    input  logic                 rst,
    input  mipsExecPkg::execReqT req,
    output mipsExecPkg::execResT res
);
    import mipsExecPkg::*;

    aluCtrlT ctrl;

    aluDecoder u_decoder (
        .instr (req.instr),
        .ctrl  (ctrl)
    );

    execStage u_exec (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .ctrl (ctrl),
        .res  (res)
    );

endmodule

/* dv/mipsExecProps.sv */
// Concurrent checks on the execute top level.
// Bound into mipsExecTop below; failCount holds the number of failed checks.

`timescale 1ns/10ps

module mipsExecProps (
    input logic                 clk,
    input logic                 rst,
    input mipsExecPkg::execReqT req,
    input mipsExecPkg::execResT res
);

    int failCount = 0;

    // Nothing leaves the stage while reset is held or on the edge after it
    assert property (@(posedge clk)
        rst |=> !res.valid && !res.writeEn && !res.ovfTrap && !res.illegal)
    else
    begin
        $error("result flags set during or right after reset");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (rst) res.writeEn |-> res.valid)
    else
    begin
        $error("write enable without a valid result");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (rst) res.ovfTrap |-> !res.writeEn)
    else
    begin
        $error("overflow trap did not block the write");
        failCount++;
    end

    assert property (@(posedge clk) disable iff (rst) req.valid |=> res.valid)
    else
    begin
        $error("valid request not answered one cycle later");
        failCount++;
    end

endmodule

bind mipsExecTop mipsExecProps u_props (.clk(clk), .rst(rst), .req(req), .res(res));

/* dv/mipsExecTb.sv */
// Directed testbench for the execute top level.
// Drives requests on the falling edge, checks each result against a reference model
// and prints one line per test, then the totals.

`timescale 1ns/10ps

module mipsExecTb;
    import mipsExecPkg::*;

    logic        clk = 1'b0;
    logic        rst;
    execReqT     req;
    execResT     res;
    logic [31:0] lfsr;
    int          errCount = 0;
    int          errMark = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    always #20 clk = ~clk;

    mipsExecTop u_dut (.clk(clk), .rst(rst), .req(req), .res(res));

    // ------------------------------------------------------------------------
    // Stimulus helpers

    function automatic logic [31:0] randBits(int nBits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nBits; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] rType(logic [5:0] op, logic [5:0] fn, logic [4:0] sa);
        return {op, 5'(randBits(5)), 5'(randBits(5)), 5'(randBits(5)), sa, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [15:0] imm);
        return {op, 5'(randBits(5)), 5'(randBits(5)), imm};
    endfunction

    function automatic execReqT mkReq(logic [31:0] instr, logic [31:0] a, logic [31:0] b);
        return '{valid: 1'b1, instr: instr, rsVal: a, rtVal: b};
    endfunction

    // ------------------------------------------------------------------------
    // Reference model

    function automatic logic signedOvf(logic [31:0] a, logic [31:0] b, logic isSub);
        logic [32:0] wide;
        wide = isSub ? ({a[31], a} - {b[31], b}) : ({a[31], a} + {b[31], b});
        return wide[32] != wide[31];
    endfunction

    function automatic logic [31:0] leadCount(logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && !v[31 - n])
            n++;
        return n;
    endfunction

    function automatic execResT refModel(execReqT q);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] si;
        logic [31:0] zi;
        logic [4:0]  sa;
        logic        trap;
        execResT     r;
        opc  = q.instr[31:26];
        fn   = q.instr[5:0];
        a    = q.rsVal;
        b    = q.rtVal;
        si   = {{16{q.instr[15]}}, q.instr[15:0]};
        zi   = {16'h0000, q.instr[15:0]};
        sa   = q.instr[10:6];
        trap = 1'b0;
        r    = '0;
        r.valid   = q.valid;
        r.writeEn = 1'b1;
        r.destReg = (opc == opSpecial || opc == opSpecial2) ? q.instr[15:11] : q.instr[20:16];
        if (opc == opSpecial)
            case (fn)
                fnAdd  :
                begin
                    r.result = a + b;
                    trap     = signedOvf(a, b, 1'b0);
                end
                fnAddu : r.result = a + b;
                fnSub  :
                begin
                    r.result = a - b;
                    trap     = signedOvf(a, b, 1'b1);
                end
                fnSubu : r.result = a - b;
                fnSll  : r.result = b << sa;
                fnSrl  : r.result = b >> sa;
                fnSra  : r.result = $signed(b) >>> sa;
                fnSllv : r.result = b << a[4:0];      // rs above 31 wraps
                fnSrlv : r.result = b >> a[4:0];
                fnSrav : r.result = $signed(b) >>> a[4:0];
                fnAnd  : r.result = a & b;
                fnOr   : r.result = a | b;
                fnNor  : r.result = ~(a | b);
                fnXor  : r.result = a ^ b;
                fnSlt  : r.result = {31'b0, $signed(a) < $signed(b)};
                fnSltu : r.result = {31'b0, a < b};
                fnMovn :
                begin
                    r.result  = a;
                    r.writeEn = (b != 0);
                end
                fnMovz :
                begin
                    r.result  = a;
                    r.writeEn = (b == 0);
                end
                default: r.illegal = 1'b1;
            endcase
        else if (opc == opSpecial2)
            case (fn)
                fnClz  : r.result = leadCount(a);
                fnClo  : r.result = leadCount(~a);
                default: r.illegal = 1'b1;
            endcase
        else
            case (opc)
                opAddi :
                begin
                    r.result = a + si;
                    trap     = signedOvf(a, si, 1'b0);
                end
                opAddiu: r.result = a + si;
                opSlti : r.result = {31'b0, $signed(a) < $signed(si)};
                opSltiu: r.result = {31'b0, a < si};
                opAndi : r.result = a & zi;
                opOri  : r.result = a | zi;
                opXori : r.result = a ^ zi;
                opLui  : r.result = {q.instr[15:0], 16'h0000};
                default: r.illegal = 1'b1;
            endcase
        r.ovfTrap = trap;
        if (trap || r.illegal)
            r.writeEn = 1'b0;
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Checking and sequencing

    task automatic checkRes(string name, execResT exp, execResT act);
        logic same;
        if (exp.illegal)   // Result and destination carry no meaning
            same = {exp.valid, exp.writeEn, exp.ovfTrap, exp.illegal}
                   === {act.valid, act.writeEn, act.ovfTrap, act.illegal};
        else
            same = (exp === act);
        if (!same)
        begin
            $display("ERROR %s: expected result=%h dest=%0d we=%b trap=%b ill=%b",
                     name, exp.result, exp.destReg, exp.writeEn, exp.ovfTrap, exp.illegal);
            $display("ERROR %s: actual   result=%h dest=%0d we=%b trap=%b ill=%b",
                     name, act.result, act.destReg, act.writeEn, act.ovfTrap, act.illegal);
            errCount++;
        end
    endtask

    task automatic issue(string name, execReqT q);
        int n;
        @(negedge clk);
        req = q;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!res.valid && n < 4);
        req.valid = 1'b0;
        if (!res.valid)
        begin
            $display("%s: no result came back within 4 cycles", name);
            errCount++;
        end
        else
            checkRes(name, refModel(q), res);
    endtask

    // One request per cycle, each result checked on the cycle after
    task automatic streamReqs(string name, execReqT qs[$]);
        for (int i = 0; i <= qs.size(); i++)
        begin
            @(negedge clk);
            if (i > 0 && !res.valid)
            begin
                $display("%s: result %0d missing one cycle after its request", name, i - 1);
                errCount++;
            end
            else if (i > 0)
                checkRes(name, refModel(qs[i - 1]), res);
            if (i < qs.size())
                req = qs[i];
            else
                req.valid = 1'b0;
        end
    endtask

    task automatic endTest(string name);
        testsRun++;
        if (errCount != errMark)
            testsFailed++;
        $display("test %-6s %s", name, (errCount == errMark) ? "ok" : "FAILED");
        errMark = errCount;
    endtask

    // ------------------------------------------------------------------------
    // Tests

    task automatic addSubTest();
        logic [5:0] fns [4] = '{fnAdd, fnAddu, fnSub, fnSubu};
        foreach (fns[i])
        begin
            issue("addsub", mkReq(rType(opSpecial, fns[i], 0), randBits(32), randBits(32)));
            issue("addsub", mkReq(rType(opSpecial, fns[i], 0), 32'h7fff_ffff, 32'h1));
            issue("addsub", mkReq(rType(opSpecial, fns[i], 0), 32'h8000_0000, 32'h1));
        end
        issue("addsub", mkReq(iType(opAddi, 16'h0001), 32'h7fff_ffff, 0));   // Traps
        issue("addsub", mkReq(iType(opAddi, 16'(randBits(16))), randBits(32), 0));
        issue("addsub", mkReq(iType(opAddiu, 16'h0001), 32'h7fff_ffff, 0));  // Wraps
        endTest("addsub");
    endtask

    task automatic logicTest();
        logic [5:0] fns [4] = '{fnAnd, fnOr, fnNor, fnXor};
        logic [5:0] ops [3] = '{opAndi, opOri, opXori};
        foreach (fns[i])
            issue("logic", mkReq(rType(opSpecial, fns[i], 0), randBits(32), randBits(32)));
        foreach (ops[i])
            issue("logic", mkReq(iType(ops[i], 16'h8000 | 16'(randBits(16))), randBits(32), 0));
        issue("logic", mkReq(iType(opAddiu, 16'hfff0), 32'h0000_0004, 0));
        issue("logic", mkReq(iType(opSlti, 16'hff00), 32'hffff_fff0, 0));
        endTest("logic");
    endtask

    task automatic shiftTest();
        logic [5:0] fix [3] = '{fnSll, fnSrl, fnSra};
        logic [5:0] vars [3] = '{fnSllv, fnSrlv, fnSrav};
        foreach (fix[i])
            issue("shift", mkReq(rType(opSpecial, fix[i], 5'(randBits(5))), 0, randBits(32)));
        foreach (vars[i])
        begin
            issue("shift", mkReq(rType(opSpecial, vars[i], 0), randBits(32), randBits(32)));
            issue("shift", mkReq(rType(opSpecial, vars[i], 0), 32'h24, 32'h8000_00f1));
        end
        issue("shift", mkReq(iType(opLui, 16'(randBits(16))), randBits(32), 0));
        endTest("shift");
    endtask

    task automatic sltTest();
        issue("slt", mkReq(rType(opSpecial, fnSlt, 0), 32'h7fff_ffff, 32'h8000_0000));
        issue("slt", mkReq(rType(opSpecial, fnSlt, 0), 32'h8000_0000, 32'h7fff_ffff));
        issue("slt", mkReq(rType(opSpecial, fnSltu, 0), 32'h7fff_ffff, 32'h8000_0000));
        issue("slt", mkReq(rType(opSpecial, fnSltu, 0), 32'hffff_ffff, 32'h1));
        issue("slt", mkReq(iType(opSlti, 16'hffff), 32'h1, 0));
        issue("slt", mkReq(iType(opSltiu, 16'hffff), 32'h1, 0));   // Imm is 0xffffffff
        issue("slt", mkReq(iType(opSltiu, 16'h0001), 32'hffff_fff0, 0));
        endTest("slt");
    endtask

    task automatic moveTest();
        issue("move", mkReq(rType(opSpecial, fnMovn, 0), randBits(32), 0));
        issue("move", mkReq(rType(opSpecial, fnMovn, 0), randBits(32), randBits(32) | 1));
        issue("move", mkReq(rType(opSpecial, fnMovz, 0), randBits(32), 0));
        issue("move", mkReq(rType(opSpecial, fnMovz, 0), randBits(32), 32'h8000_0000));
        issue("move", mkReq(iType(6'h3f, 16'(randBits(16))), randBits(32), randBits(32)));
        issue("move", mkReq(rType(opSpecial, 6'h3f, 0), randBits(32), randBits(32)));
        endTest("move");
    endtask

    task automatic countTest();
        execReqT     qs[$];
        logic [31:0] vals [6];
        vals = '{32'h0, 32'hffff_ffff, 32'h1 << randBits(5), ~(32'h1 << randBits(5)),
                 randBits(32), randBits(32) >> randBits(5)};
        foreach (vals[i])
        begin
            qs.push_back(mkReq(rType(opSpecial2, fnClz, 0), vals[i], randBits(32)));
            qs.push_back(mkReq(rType(opSpecial2, fnClo, 0), vals[i], randBits(32)));
        end
        streamReqs("count", qs);
        endTest("count");
    endtask

    initial
    begin
        req  = '0;
        rst  = 1'b1;
        lfsr = 32'h37ad_e2e7;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        addSubTest();
        logicTest();
        shiftTest();
        sltTest();
        moveTest();
        countTest();
        $display("%0d tests run, %0d failing, %0d errors, %0d assertion failures",
                 testsRun, testsFailed, errCount, u_dut.u_props.failCount);
        if (errCount == 0 && u_dut.u_props.failCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* build.f */
hw/mipsExecPkg.sv
hw/aluDecoder.sv
hw/alu.sv
hw/execStage.sv
hw/mipsExecTop.sv
dv/mipsExecProps.sv
dv/mipsExecTb.sv
